// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_periph_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
EXTRA_ARGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP) $(EXTRA_ARGS)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP) $(EXTRA_ARGS)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: periph_bus_ctrl.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_bus_ctrl import periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  reg_req_t                  req_i,
    output reg_resp_t                 resp_o,
    output slv_req_t                  tmr_req_o,
    input  logic [`PERIPH_DATA_W-1:0] tmr_rdata_i,
    input  logic                      tmr_err_i,
    output slv_req_t                  plic_req_o,
    input  logic [`PERIPH_DATA_W-1:0] plic_rdata_i,
    input  logic                      plic_err_i
);

    bus_state_e                state_q, state_d;
    region_e                   region_d, region_q;
    acc_op_e                   op_q;
    logic [`PERIPH_OFFS_W-1:0] offset_q;
    logic [`PERIPH_DATA_W-1:0] wdata_q;
    logic [`PERIPH_ADDR_W-1:0] region_addr;
    logic                      acc_err;
    logic [`PERIPH_DATA_W-1:0] acc_rdata;
    logic                      ready_q;
    logic                      err_q;
    logic [`PERIPH_DATA_W-1:0] rdata_q;

    // ------------------------------------------------------------------------
    // Region decode and FSM
    // ------------------------------------------------------------------------
    assign region_addr = req_i.addr & ~(`PERIPH_REGION_SPAN - 12'h1);

    always_comb begin
        if (region_addr == `PERIPH_TIMER_BASE) begin
            region_d = REGION_TIMER;
        end else if (region_addr == `PERIPH_PLIC_BASE) begin
            region_d = REGION_PLIC;
        end else begin
            region_d = REGION_NONE;
        end
    end

    always_comb begin
        case (state_q)
            BUS_IDLE:   state_d = req_i.valid ? BUS_ACCESS : BUS_IDLE;
            BUS_ACCESS: state_d = BUS_RESP;
            default:    state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= BUS_IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_q == BUS_RESP);
        end
    end

    // Request capture and response data
    always_ff @(posedge clk_i) begin
        if (state_q == BUS_IDLE && req_i.valid) begin
            region_q <= region_d;
            op_q     <= acc_op_e'(req_i.write);
            offset_q <= req_i.addr[`PERIPH_OFFS_W-1:0];
            wdata_q  <= req_i.wdata;
        end
        if (state_q == BUS_ACCESS) begin
            err_q   <= acc_err;
            rdata_q <= acc_rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Slave strobes and response mux
    // ------------------------------------------------------------------------
    always_comb begin
        tmr_req_o         = '0;
        plic_req_o        = '0;
        tmr_req_o.offset  = offset_q;
        tmr_req_o.wdata   = wdata_q;
        plic_req_o.offset = offset_q;
        plic_req_o.wdata  = wdata_q;
        if (state_q == BUS_ACCESS) begin
            case (region_q)
                REGION_TIMER: begin
                    tmr_req_o.rd = (op_q == OP_READ);
                    tmr_req_o.wr = (op_q == OP_WRITE);
                end
                REGION_PLIC: begin
                    plic_req_o.rd = (op_q == OP_READ);
                    plic_req_o.wr = (op_q == OP_WRITE);
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (region_q)
            REGION_TIMER: begin
                acc_err   = tmr_err_i;
                acc_rdata = tmr_err_i ? `PERIPH_ERR_DATA : tmr_rdata_i;
            end
            REGION_PLIC: begin
                acc_err   = plic_err_i;
                acc_rdata = plic_err_i ? `PERIPH_ERR_DATA : plic_rdata_i;
            end
            default: begin
                acc_err   = 1'b1;
                acc_rdata = `PERIPH_ERR_DATA;
            end
        endcase
    end

    assign resp_o.ready = ready_q;
    assign resp_o.error = err_q;
    assign resp_o.rdata = rdata_q;

endmodule

// File: periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus widths
`define PERIPH_ADDR_W       12
`define PERIPH_DATA_W       32
`define PERIPH_OFFS_W       8

// Region map, 0x100 bytes each
`define PERIPH_REGION_SPAN  12'h100
`define PERIPH_TIMER_BASE   12'h000
`define PERIPH_PLIC_BASE    12'h100

// Block sizes
`define PERIPH_NUM_TIMERS   2
`define PERIPH_NUM_SOURCES  4
`define PERIPH_NUM_TARGETS  2
`define PERIPH_PRIO_W       3

// Timer registers, repeated per timer
`define PERIPH_TMR_CTRL     8'h00
`define PERIPH_TMR_COUNT    8'h04
`define PERIPH_TMR_CMP      8'h08
`define PERIPH_TMR_STATUS   8'h0C
`define PERIPH_TMR_STRIDE   8'h10

// PLIC register groups
`define PERIPH_PLIC_PRIO    8'h00
`define PERIPH_PLIC_ENABLE  8'h40
`define PERIPH_PLIC_THRESH  8'h80
`define PERIPH_PLIC_CLAIM   8'hC0

// Answer of unmapped or missing registers
`define PERIPH_ERR_DATA     32'hDEADBEEF

`endif

// File: periph_pkg.sv
`include "periph_consts.svh"

package periph_pkg;

    // Register bus request, valid is a single-cycle strobe
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                      ready;
        logic                      error;
        logic [`PERIPH_DATA_W-1:0] rdata;
    } reg_resp_t;

    // Access toward one slave
    typedef struct packed {
        logic                      rd;
        logic                      wr;
        logic [`PERIPH_OFFS_W-1:0] offset;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } slv_req_t;

    typedef enum logic [1:0] {
        BUS_IDLE   = 2'd0,
        BUS_ACCESS = 2'd1,
        BUS_RESP   = 2'd2
    } bus_state_e;

    typedef enum logic [1:0] {
        REGION_TIMER = 2'd0,
        REGION_PLIC  = 2'd1,
        REGION_NONE  = 2'd2
    } region_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } acc_op_e;

endpackage

// File: periph_plic.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_plic import periph_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  slv_req_t                       slv_i,
    output logic [`PERIPH_DATA_W-1:0]      rdata_o,
    output logic                           err_o,
    input  logic [`PERIPH_NUM_SOURCES-1:0] irq_src_i,
    output logic [`PERIPH_NUM_TARGETS-1:0] eip_o
);

    localparam int NUM_SRC = `PERIPH_NUM_SOURCES;
    localparam int NUM_TGT = `PERIPH_NUM_TARGETS;
    localparam int ID_W    = $clog2(NUM_SRC + 1);
    localparam int TGT_W   = $clog2(NUM_TGT);

    logic [`PERIPH_PRIO_W-1:0] prio_q   [1:NUM_SRC];
    logic [NUM_SRC:1]          en_q     [NUM_TGT];
    logic [`PERIPH_PRIO_W-1:0] thresh_q [NUM_TGT];
    logic [NUM_SRC:1]          claimed_q;
    logic [NUM_TGT-1:0]        eip_q;

    logic [NUM_SRC:1]          elig     [NUM_TGT];
    logic [ID_W-1:0]           claim_id [NUM_TGT];
    logic [`PERIPH_OFFS_W-1:0] grp;
    logic [`PERIPH_OFFS_W-1:0] idx;
    logic [ID_W-1:0]           src_sel;
    logic [TGT_W-1:0]          tgt;
    logic                      hit;
    logic                      cpl_ok;
    logic [ID_W-1:0]           cpl_id;

    // ------------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------------
    assign grp     = slv_i.offset & 8'hC0;
    assign idx     = (slv_i.offset & 8'h3C) >> 2;
    assign src_sel = idx[ID_W-1:0];
    assign tgt     = idx[TGT_W-1:0];

    always_comb begin
        if (slv_i.offset[1:0] != 2'b00) begin
            hit = 1'b0;
        end else if (grp == `PERIPH_PLIC_PRIO) begin
            hit = (idx <= 8'(NUM_SRC));
        end else begin
            hit = (idx < 8'(NUM_TGT));
        end
    end

    // Completion id, only ids 1..NUM_SRC count
    assign cpl_ok = (slv_i.wdata != '0) && (slv_i.wdata <= 32'(NUM_SRC));
    assign cpl_id = slv_i.wdata[ID_W-1:0];

    // ------------------------------------------------------------------------
    // Eligibility and arbitration
    // ------------------------------------------------------------------------
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            for (int s = 1; s <= NUM_SRC; s++) begin
                elig[t][s] = irq_src_i[s-1] && !claimed_q[s] && en_q[t][s] &&
                             (prio_q[s] > thresh_q[t]);
            end
        end
    end

    // Strict compare keeps the lower id on equal priority
    always_comb begin
        logic [`PERIPH_PRIO_W-1:0] best;
        for (int t = 0; t < NUM_TGT; t++) begin
            best        = '0;
            claim_id[t] = '0;
            for (int s = 1; s <= NUM_SRC; s++) begin
                if (elig[t][s] && prio_q[s] > best) begin
                    best        = prio_q[s];
                    claim_id[t] = ID_W'(s);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 1; s <= NUM_SRC; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NUM_TGT; t++) begin
                en_q[t]     <= '0;
                thresh_q[t] <= '0;
            end
            claimed_q <= '0;
            eip_q     <= '0;
        end else begin
            if (slv_i.wr && hit) begin
                case (grp)
                    `PERIPH_PLIC_PRIO: begin
                        if (src_sel != '0) begin
                            prio_q[src_sel] <= slv_i.wdata[`PERIPH_PRIO_W-1:0];
                        end
                    end
                    `PERIPH_PLIC_ENABLE: en_q[tgt]     <= slv_i.wdata[NUM_SRC:1];
                    `PERIPH_PLIC_THRESH: thresh_q[tgt] <= slv_i.wdata[`PERIPH_PRIO_W-1:0];
                    default: ;
                endcase
            end
            // Claim on read, complete on write
            if (slv_i.rd && hit && grp == `PERIPH_PLIC_CLAIM && claim_id[tgt] != '0) begin
                claimed_q[claim_id[tgt]] <= 1'b1;
            end
            if (slv_i.wr && hit && grp == `PERIPH_PLIC_CLAIM && cpl_ok) begin
                claimed_q[cpl_id] <= 1'b0;
            end
            for (int t = 0; t < NUM_TGT; t++) begin
                eip_q[t] <= |elig[t];
            end
        end
    end

    assign eip_o = eip_q;

    always_comb begin
        rdata_o = '0;
        err_o   = !hit;
        if (hit) begin
            case (grp)
                `PERIPH_PLIC_PRIO: begin
                    if (src_sel != '0) begin
                        rdata_o = 32'(prio_q[src_sel]);
                    end
                end
                `PERIPH_PLIC_ENABLE: rdata_o = 32'({en_q[tgt], 1'b0});
                `PERIPH_PLIC_THRESH: rdata_o = 32'(thresh_q[tgt]);
                default:             rdata_o = 32'(claim_id[tgt]);
            endcase
        end
    end

endmodule

// File: periph_timer.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_timer import periph_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  slv_req_t                      slv_i,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output logic                          err_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] irq_o
);

    localparam int NUM_TIMERS = `PERIPH_NUM_TIMERS;
    localparam int SEL_W      = $clog2(NUM_TIMERS);

    logic [`PERIPH_OFFS_W-1:0] tmr_sel;
    logic [`PERIPH_OFFS_W-1:0] reg_off;
    logic [SEL_W-1:0]          idx;
    logic                      hit;
    logic [NUM_TIMERS-1:0]     wr_sel;
    logic [NUM_TIMERS-1:0]     match;

    logic                      en_q     [NUM_TIMERS];
    logic [`PERIPH_DATA_W-1:0] count_q  [NUM_TIMERS];
    logic [`PERIPH_DATA_W-1:0] cmp_q    [NUM_TIMERS];
    logic                      status_q [NUM_TIMERS];

    // Offset split into timer and register
    assign tmr_sel = slv_i.offset / `PERIPH_TMR_STRIDE;
    assign reg_off = slv_i.offset % `PERIPH_TMR_STRIDE;
    assign idx     = tmr_sel[SEL_W-1:0];
    assign hit     = (tmr_sel < 8'(NUM_TIMERS)) && (reg_off[1:0] == 2'b00);

    always_comb begin
        for (int t = 0; t < NUM_TIMERS; t++) begin
            wr_sel[t] = slv_i.wr && hit && (tmr_sel == 8'(t));
            match[t]  = en_q[t] && (count_q[t] == cmp_q[t]);
            irq_o[t]  = status_q[t];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int t = 0; t < NUM_TIMERS; t++) begin
                en_q[t]     <= 1'b0;
                count_q[t]  <= '0;
                cmp_q[t]    <= '0;
                status_q[t] <= 1'b0;
            end
        end else begin
            for (int t = 0; t < NUM_TIMERS; t++) begin
                if (wr_sel[t] && reg_off == `PERIPH_TMR_CTRL) begin
                    en_q[t] <= slv_i.wdata[0];
                end
                if (wr_sel[t] && reg_off == `PERIPH_TMR_CMP) begin
                    cmp_q[t] <= slv_i.wdata;
                end
                // Software write wins over counting
                if (wr_sel[t] && reg_off == `PERIPH_TMR_COUNT) begin
                    count_q[t] <= slv_i.wdata;
                end else if (match[t]) begin
                    count_q[t] <= '0;
                end else if (en_q[t]) begin
                    count_q[t] <= count_q[t] + 1'b1;
                end
                if (match[t]) begin
                    status_q[t] <= 1'b1;
                end else if (wr_sel[t] && reg_off == `PERIPH_TMR_STATUS && slv_i.wdata[0]) begin
                    status_q[t] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        err_o   = !hit;
        if (hit) begin
            case (reg_off)
                `PERIPH_TMR_CTRL:   rdata_o = 32'(en_q[idx]);
                `PERIPH_TMR_COUNT:  rdata_o = count_q[idx];
                `PERIPH_TMR_CMP:    rdata_o = cmp_q[idx];
                `PERIPH_TMR_STATUS: rdata_o = 32'(status_q[idx]);
                default:            rdata_o = '0;
            endcase
        end
    end

endmodule

// File: periph_top.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_top import periph_pkg::*; (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    input  reg_req_t                                          req_i,
    output reg_resp_t                                         resp_o,
    input  logic [`PERIPH_NUM_SOURCES-`PERIPH_NUM_TIMERS-1:0] irq_ext_i,
    output logic [`PERIPH_NUM_TARGETS-1:0]                    eip_o
);

    slv_req_t                      tmr_req;
    slv_req_t                      plic_req;
    logic [`PERIPH_DATA_W-1:0]     tmr_rdata;
    logic [`PERIPH_DATA_W-1:0]     plic_rdata;
    logic                          tmr_err;
    logic                          plic_err;
    logic [`PERIPH_NUM_TIMERS-1:0] tmr_irq;
    logic [`PERIPH_NUM_SOURCES-1:0] irq_src;

    // Ids 1-2 external, ids 3-4 timers
    assign irq_src = {tmr_irq, irq_ext_i};

    periph_bus_ctrl i_bus_ctrl (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .req_i        ( req_i      ),
        .resp_o       ( resp_o     ),
        .tmr_req_o    ( tmr_req    ),
        .tmr_rdata_i  ( tmr_rdata  ),
        .tmr_err_i    ( tmr_err    ),
        .plic_req_o   ( plic_req   ),
        .plic_rdata_i ( plic_rdata ),
        .plic_err_i   ( plic_err   )
    );

    periph_timer i_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .slv_i   ( tmr_req   ),
        .rdata_o ( tmr_rdata ),
        .err_o   ( tmr_err   ),
        .irq_o   ( tmr_irq   )
    );

    periph_plic i_plic (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n_i    ),
        .slv_i     ( plic_req   ),
        .rdata_o   ( plic_rdata ),
        .err_o     ( plic_err   ),
        .irq_src_i ( irq_src    ),
        .eip_o     ( eip_o      )
    );

endmodule

// File: tb.f
+incdir+.
periph_pkg.sv
periph_bus_ctrl.sv
periph_timer.sv
periph_plic.sv
periph_top.sv
tb_periph_top.sv

// File: tb_periph_top.sv
`timescale 1ns/1ps
`include "periph_consts.svh"

module tb_periph_top import periph_pkg::*; ();

    localparam int PRIO_W          = `PERIPH_PRIO_W;
    localparam int NUM_SRC         = `PERIPH_NUM_SOURCES;
    localparam int NUM_TGT         = `PERIPH_NUM_TARGETS;
    localparam int NUM_EXT         = `PERIPH_NUM_SOURCES - `PERIPH_NUM_TIMERS;
    localparam int NUM_ROUNDS      = 8;
    // Rounded-up count of bus operations over all tests
    localparam int NUM_OPS         = 48 + NUM_ROUNDS * 12;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 200;
    localparam int RESP_LATENCY    = 2;
    localparam int RESP_LIMIT      = 10;

    typedef struct packed {
        logic                      chk;
        logic                      err;
        logic [`PERIPH_DATA_W-1:0] data;
        logic [`PERIPH_ADDR_W-1:0] addr;
    } exp_resp_t;

    logic               clk_i;
    logic               rst_n_i;
    reg_req_t           req_i;
    reg_resp_t          resp_o;
    logic [NUM_EXT-1:0] irq_ext_i;
    logic [NUM_TGT-1:0] eip_o;

    integer             seed;
    int                 errors;
    exp_resp_t          exp_q[$];

    // Reference copies of the PLIC state
    logic [PRIO_W-1:0]  prio_m    [1:NUM_SRC];
    logic [NUM_SRC:1]   en_m      [NUM_TGT];
    logic [PRIO_W-1:0]  thresh_m  [NUM_TGT];
    logic [NUM_SRC:1]   claimed_m;
    logic [NUM_EXT-1:0] ext_m;

    periph_top dut0 (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .req_i     ( req_i     ),
        .resp_o    ( resp_o    ),
        .irq_ext_i ( irq_ext_i ),
        .eip_o     ( eip_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    // Highest priority eligible id with ties to the lower id
    // Timer sources stay low throughout
    function automatic logic [2:0] ref_claim(input int tgt);
        logic [2:0]        id;
        logic [PRIO_W-1:0] best;
        logic [NUM_SRC:1]  lvl;
        id   = 3'd0;
        best = '0;
        lvl  = {{(NUM_SRC-NUM_EXT){1'b0}}, ext_m};
        for (int s = 1; s <= NUM_SRC; s++) begin
            if (lvl[s] && !claimed_m[s] && en_m[tgt][s] && prio_m[s] > thresh_m[tgt]) begin
                if (prio_m[s] > best) begin
                    best = prio_m[s];
                    id   = 3'(s);
                end
            end
        end
        return id;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    always @(posedge clk_i) begin
        exp_resp_t e;
        if (resp_o.ready === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Response arrived while no access was pending");
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                expect_equal($sformatf("resp_o.error @%h", e.addr), 32'(e.err),
                             32'(resp_o.error));
                if (e.chk) begin
                    expect_equal($sformatf("resp_o.rdata @%h", e.addr), e.data,
                                 resp_o.rdata);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Bus and PLIC tasks
    // ------------------------------------------------------------------------
    task automatic bus_access(input acc_op_e op, input logic [`PERIPH_ADDR_W-1:0] addr,
                              input logic [`PERIPH_DATA_W-1:0] wdata, input logic exp_err,
                              input logic chk, input logic [`PERIPH_DATA_W-1:0] exp_data);
        exp_resp_t e;
        int        edges;
        e.chk  = chk;
        e.err  = exp_err;
        e.data = exp_data;
        e.addr = addr;
        exp_q.push_back(e);
        @(posedge clk_i);
        req_i.valid <= 1'b1;
        req_i.write <= (op == OP_WRITE);
        req_i.addr  <= addr;
        req_i.wdata <= wdata;
        // DUT samples the request here
        @(posedge clk_i);
        req_i.valid <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
        end while (!resp_o.ready && edges < RESP_LIMIT);
        assert (resp_o.ready) else begin
            errors++;
            $display("No response for address %h within %0d cycles", addr, RESP_LIMIT);
        end
        if (resp_o.ready) begin
            assert (edges - 1 == RESP_LATENCY) else begin
                errors++;
                $display("Response for address %h came %0d cycles after the request, not %0d",
                         addr, edges - 1, RESP_LATENCY);
            end
        end
    endtask

    task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr,
                             input logic [`PERIPH_DATA_W-1:0] data);
        bus_access(OP_WRITE, addr, data, 1'b0, 1'b0, '0);
    endtask

    task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr,
                            input logic [`PERIPH_DATA_W-1:0] exp);
        bus_access(OP_READ, addr, '0, 1'b0, 1'b1, exp);
    endtask

    function automatic logic [`PERIPH_ADDR_W-1:0] tmr_addr(input int t, input logic [7:0] off);
        return `PERIPH_TIMER_BASE + 12'(t) * 12'(`PERIPH_TMR_STRIDE) + 12'(off);
    endfunction

    function automatic logic [`PERIPH_ADDR_W-1:0] plic_addr(input logic [7:0] grp, input int i);
        return `PERIPH_PLIC_BASE + 12'(grp) + 12'(4 * i);
    endfunction

    task automatic set_prio(input int id, input logic [PRIO_W-1:0] p);
        prio_m[id] = p;
        bus_write(plic_addr(`PERIPH_PLIC_PRIO, id), 32'(p));
    endtask

    task automatic set_enable(input int t, input logic [NUM_SRC:1] en);
        en_m[t] = en;
        bus_write(plic_addr(`PERIPH_PLIC_ENABLE, t), 32'({en, 1'b0}));
    endtask

    task automatic set_thresh(input int t, input logic [PRIO_W-1:0] th);
        thresh_m[t] = th;
        bus_write(plic_addr(`PERIPH_PLIC_THRESH, t), 32'(th));
    endtask

    task automatic drive_ext(input logic [NUM_EXT-1:0] lvl);
        @(posedge clk_i);
        irq_ext_i <= lvl;
        ext_m = lvl;
    endtask

    // eip_o is registered behind the source levels
    task automatic check_eip();
        repeat (2) @(posedge clk_i);
        expect_equal("eip_o", 32'({ref_claim(1) != 3'd0, ref_claim(0) != 3'd0}), 32'(eip_o));
    endtask

    task automatic claim_check(input int t);
        logic [2:0] id;
        id = ref_claim(t);
        bus_read(plic_addr(`PERIPH_PLIC_CLAIM, t), 32'(id));
        if (id != 3'd0) begin
            claimed_m[id] = 1'b1;
        end
    endtask

    task automatic complete(input int id);
        bus_write(plic_addr(`PERIPH_PLIC_CLAIM, 0), 32'(id));
        claimed_m[id] = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [`PERIPH_DATA_W-1:0] cnt_m [`PERIPH_NUM_TIMERS];
        logic [`PERIPH_DATA_W-1:0] cmp_m [`PERIPH_NUM_TIMERS];
        logic [`PERIPH_ADDR_W-1:0] bad_addr;
        seed      = 32'h3044;
        errors    = 0;
        rst_n_i   = 1'b0;
        req_i     = '0;
        irq_ext_i = '0;
        ext_m     = '0;
        claimed_m = '0;
        for (int s = 1; s <= NUM_SRC; s++) begin
            prio_m[s] = '0;
        end
        for (int t = 0; t < NUM_TGT; t++) begin
            en_m[t]     = '0;
            thresh_m[t] = '0;
        end
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Timer register round trip while both timers are disabled
        for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
            cnt_m[t] = $random(seed);
            cmp_m[t] = $random(seed);
            bus_write(tmr_addr(t, `PERIPH_TMR_COUNT), cnt_m[t]);
            bus_write(tmr_addr(t, `PERIPH_TMR_CMP), cmp_m[t]);
            bus_read(tmr_addr(t, `PERIPH_TMR_COUNT), cnt_m[t]);
            bus_read(tmr_addr(t, `PERIPH_TMR_CMP), cmp_m[t]);
        end

        // Unmapped space where 0x204 aliases timer 0 COUNT in its low byte
        bad_addr = 12'h200 | (12'($random(seed)) & 12'hFFC);
        bus_access(OP_WRITE, bad_addr, ~cnt_m[0], 1'b1, 1'b1, `PERIPH_ERR_DATA);
        bus_access(OP_WRITE, 12'h204, ~cnt_m[0], 1'b1, 1'b1, `PERIPH_ERR_DATA);
        bus_access(OP_READ, 12'hF04, '0, 1'b1, 1'b1, `PERIPH_ERR_DATA);
        for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
            bus_read(tmr_addr(t, `PERIPH_TMR_COUNT), cnt_m[t]);
            bus_read(tmr_addr(t, `PERIPH_TMR_CMP), cmp_m[t]);
        end

        // Timer 0 match sets the sticky status
        bus_write(tmr_addr(0, `PERIPH_TMR_CMP), 32'd5);
        bus_write(tmr_addr(0, `PERIPH_TMR_COUNT), 32'd0);
        bus_write(tmr_addr(0, `PERIPH_TMR_CTRL), 32'd1);
        repeat (20) @(posedge clk_i);
        bus_read(tmr_addr(0, `PERIPH_TMR_STATUS), 32'd1);
        bus_read(tmr_addr(1, `PERIPH_TMR_STATUS), 32'd0);
        // Push the next match far out, then clear
        bus_write(tmr_addr(0, `PERIPH_TMR_CMP), 32'd1000);
        bus_write(tmr_addr(0, `PERIPH_TMR_STATUS), 32'd1);
        bus_read(tmr_addr(0, `PERIPH_TMR_STATUS), 32'd0);
        bus_write(tmr_addr(0, `PERIPH_TMR_CTRL), 32'd0);
        bus_write(tmr_addr(0, `PERIPH_TMR_STATUS), 32'd1);

        // Random priorities, enables and levels
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            for (int s = 1; s <= NUM_SRC; s++) begin
                set_prio(s, PRIO_W'($random(seed)));
            end
            for (int t = 0; t < NUM_TGT; t++) begin
                set_enable(t, NUM_SRC'($random(seed)));
                set_thresh(t, '0);
            end
            drive_ext(NUM_EXT'($random(seed)));
            check_eip();
            claim_check(0);
            claim_check(1);
            check_eip();
            for (int s = 1; s <= NUM_SRC; s++) begin
                if (claimed_m[s]) begin
                    complete(s);
                end
            end
        end

        // Threshold masking, then claim and complete
        set_enable(1, '0);
        set_enable(0, 4'b0011);
        set_prio(1, 3'd5);
        set_prio(2, 3'd2);
        drive_ext(2'b11);
        set_thresh(0, 3'd5);
        check_eip();
        claim_check(0);
        set_thresh(0, 3'd1);
        check_eip();
        claim_check(0);
        claim_check(0);
        claim_check(0);
        check_eip();
        complete(1);
        check_eip();
        claim_check(0);
        complete(1);
        complete(2);
        check_eip();

        repeat (4) @(posedge clk_i);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
